/* common/axil_rd_if.sv */
/* AXI4-Lite read channel
   single beat reads, one outstanding */
`timescale 1ns/1ns
interface axil_rd_if
  import hawk_pkg::*;
();

  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;   // OKAY or SLVERR only
  logic              rvalid;
  logic              rready;

  modport manager (
    output araddr, arvalid, rready,
    input  arready, rdata, rresp, rvalid
  );

  modport subordinate (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );

endinterface

/* common/axil_wr_if.sv */
/* AXI4-Lite write channel
   address and data raised together, full word writes */
`timescale 1ns/1ns
interface axil_wr_if
  import hawk_pkg::*;
();

  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;

  modport manager (
    output awaddr, awvalid, wdata, wvalid, bready,
    input  awready, wready, bresp, bvalid
  );

  modport subordinate (
    input  awaddr, awvalid, wdata, wvalid, bready,
    output awready, wready, bresp, bvalid
  );

endinterface

/* common/hawk_pkg.sv */
/* hawk shared definitions
   table geometry, address map, entry formats and FSM encodings */
package hawk_pkg;

  localparam int DATA_W      = 32;  // table word
  localparam int ADDR_W      = 12;  // byte address into the table memory
  localparam int HPPA_W      = 8;   // host page number
  localparam int PPA_W       = 3;   // physical page number
  localparam int ATT_ENTRIES = 16;
  localparam int ATT_ID_W    = 4;   // index bits for ATT_ENTRIES
  localparam int TOL_ENTRIES = 8;   // page 0 never handed out

  localparam logic [HPPA_W-1:0] HPPA_BASE = 8'h40;    // first host page in the ATT
  localparam logic [ADDR_W-1:0] ATT_BASE  = 12'h000;
  localparam logic [ADDR_W-1:0] TOL_BASE  = 12'h400;
  localparam logic [PPA_W-1:0]  NULL_PAGE = '0;       // empty list / end of chain

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // ATT entry status, bits 1:0 of an ATT word
  typedef enum logic [1:0] {
    STS_DALLOC = 2'd0,
    STS_UNCOMP = 2'd1,
    STS_INCOMP = 2'd2,
    STS_COMP   = 2'd3   // never written by this engine
  } att_sts_e;

  typedef enum logic [3:0] {
    IDLE, LOOKUP_ATT, WAIT_ATT, DECODE_ATT, POP_FREE, WAIT_TOL, ALLOCATE, BUS_ERROR
  } pgrd_state_e;

  typedef enum logic [1:0] {W_IDLE, W_ADDR, W_RESP} pgwr_state_e;

  // read manager -> write manager
  typedef struct packed {
    logic [ATT_ID_W-1:0] att_id;
    logic [PPA_W-1:0]    ppa;        // page popped from the free list
    logic [PPA_W-1:0]    next_free;  // new free list head
  } tbl_upd_t;

  typedef struct packed {
    logic             allow;
    att_sts_e         sts;
    logic [PPA_W-1:0] ppa;
  } trnsl_resp_t;

  // ATT word: sts in 1:0, ppa in 6:4
  function automatic logic [DATA_W-1:0] att_word(input att_sts_e sts,
                                                 input logic [PPA_W-1:0] ppa);
    logic [DATA_W-1:0] w;
    w = '0;
    w[1:0] = sts;
    w[4 +: PPA_W] = ppa;
    return w;
  endfunction

  function automatic att_sts_e att_sts(input logic [DATA_W-1:0] w);
    return att_sts_e'(w[1:0]);
  endfunction

  function automatic logic [PPA_W-1:0] att_ppa(input logic [DATA_W-1:0] w);
    return w[4 +: PPA_W];
  endfunction

  // TOL word: next free page in the low bits
  function automatic logic [DATA_W-1:0] tol_word(input logic [PPA_W-1:0] next);
    return DATA_W'(next);
  endfunction

  function automatic logic [PPA_W-1:0] tol_next(input logic [DATA_W-1:0] w);
    return w[PPA_W-1:0];
  endfunction

endpackage

/* pgrd_mngr/hawk_pgrd_mngr.sv */
/* hawk page read manager
   reads the ATT entry of a host page, grants hits, pops the free list on a miss
   and hands the new mapping to the page write manager */
`timescale 1ns/1ns
module hawk_pgrd_mngr
  import hawk_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              lookup_valid,
  input  logic [HPPA_W-1:0] lookup_hppa,
  output logic              lookup_ready,
  axil_rd_if.manager        axi_rd,
  input  logic [PPA_W-1:0]  free_head,
  output logic              upd_valid,
  output tbl_upd_t          upd,
  input  logic              upd_ready,
  output logic              trnsl_valid,
  output trnsl_resp_t       trnsl_resp,
  output logic              bus_error
);

  pgrd_state_e state_q;

  // control
  logic arvalid_q;
  logic rready_q;
  logic upd_valid_q;
  logic trnsl_valid_q;
  logic bus_error_q;

  // payload
  logic [HPPA_W-1:0] att_id_q;  // full 8 bits, ids >= 16 fall in unmapped space
  logic [ADDR_W-1:0] araddr_q;
  logic [DATA_W-1:0] rdata_q;   // ATT word under decode
  logic [PPA_W-1:0]  page_q;    // popped free page
  tbl_upd_t          upd_q;
  trnsl_resp_t       trnsl_resp_q;

  logic lookup_fire;
  logic ar_fire;
  logic r_fire;
  logic r_ok;
  logic upd_fire;
  logic att_hit;
  logic list_empty;

  assign lookup_ready = (state_q == IDLE) && upd_ready;  // previous ATT write finished
  assign lookup_fire  = lookup_valid & lookup_ready;
  assign ar_fire      = arvalid_q & axi_rd.arready;
  assign r_fire       = rready_q & axi_rd.rvalid;
  assign r_ok         = (axi_rd.rresp == RESP_OKAY);
  assign upd_fire     = upd_valid_q & upd_ready;
  assign att_hit      = (att_sts(rdata_q) != STS_DALLOC);  // uncomp or incomp
  assign list_empty   = (free_head == NULL_PAGE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      arvalid_q     <= 1'b0;
      rready_q      <= 1'b0;
      upd_valid_q   <= 1'b0;
      trnsl_valid_q <= 1'b0;
      bus_error_q   <= 1'b0;
    end else begin
      trnsl_valid_q <= 1'b0;  // one cycle pulse
      if (ar_fire) begin
        arvalid_q <= 1'b0;    // address taken
      end
      if (r_fire) begin
        rready_q <= 1'b0;     // data taken
      end
      case (state_q)
        IDLE: begin
          if (lookup_fire) begin
            state_q <= LOOKUP_ATT;
          end
        end
        LOOKUP_ATT: begin
          arvalid_q <= 1'b1;  // issue ATT read
          rready_q  <= 1'b1;
          state_q   <= WAIT_ATT;
        end
        WAIT_ATT: begin
          if (r_fire) begin
            if (r_ok) begin
              state_q <= DECODE_ATT;
            end else begin
              state_q     <= BUS_ERROR;
              bus_error_q <= 1'b1;
            end
          end
        end
        DECODE_ATT: begin
          if (att_hit || list_empty) begin
            trnsl_valid_q <= 1'b1;  // hit or denied
            state_q       <= IDLE;
          end else begin
            state_q <= POP_FREE;
          end
        end
        POP_FREE: begin
          arvalid_q <= 1'b1;  // read TOL entry of the head page
          rready_q  <= 1'b1;
          state_q   <= WAIT_TOL;
        end
        WAIT_TOL: begin
          if (r_fire) begin
            if (r_ok) begin
              upd_valid_q <= 1'b1;
              state_q     <= ALLOCATE;
            end else begin
              state_q     <= BUS_ERROR;
              bus_error_q <= 1'b1;
            end
          end
        end
        ALLOCATE: begin
          if (upd_fire) begin  // hold update until the write manager takes it
            upd_valid_q   <= 1'b0;
            trnsl_valid_q <= 1'b1;
            state_q       <= IDLE;
          end
        end
        BUS_ERROR: begin
          state_q <= BUS_ERROR;  // sticky until reset
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      IDLE: begin
        if (lookup_fire) begin
          att_id_q <= lookup_hppa - HPPA_BASE;  // wraps for hppa below base
        end
      end
      LOOKUP_ATT: begin
        araddr_q <= ATT_BASE + ADDR_W'({att_id_q, 2'b00});
      end
      WAIT_ATT: begin
        if (r_fire) begin
          rdata_q <= axi_rd.rdata;
        end
      end
      DECODE_ATT: begin
        page_q <= free_head;
        if (att_hit) begin
          trnsl_resp_q <= '{allow: 1'b1, sts: att_sts(rdata_q), ppa: att_ppa(rdata_q)};
        end else if (list_empty) begin
          trnsl_resp_q <= '{allow: 1'b0, sts: STS_DALLOC, ppa: NULL_PAGE};
        end
      end
      POP_FREE: begin
        araddr_q <= TOL_BASE + ADDR_W'({page_q, 2'b00});
      end
      WAIT_TOL: begin
        if (r_fire) begin
          upd_q <= '{att_id:    att_id_q[ATT_ID_W-1:0],
                     ppa:       page_q,
                     next_free: tol_next(axi_rd.rdata)};
        end
      end
      ALLOCATE: begin
        if (upd_fire) begin
          trnsl_resp_q <= '{allow: 1'b1, sts: STS_UNCOMP, ppa: page_q};
        end
      end
      default: begin
      end
    endcase
  end

  assign axi_rd.araddr  = araddr_q;
  assign axi_rd.arvalid = arvalid_q;
  assign axi_rd.rready  = rready_q;
  assign upd_valid      = upd_valid_q;
  assign upd            = upd_q;
  assign trnsl_valid    = trnsl_valid_q;
  assign trnsl_resp     = trnsl_resp_q;
  assign bus_error      = bus_error_q;

endmodule

/* pgwr_mngr/hawk_pgwr_mngr.sv */
/* hawk page write manager
   writes new ATT entries and owns the free list head */
`timescale 1ns/1ns
module hawk_pgwr_mngr
  import hawk_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             upd_valid,
  input  tbl_upd_t         upd,
  output logic             upd_ready,
  axil_wr_if.manager       axi_wr,
  output logic [PPA_W-1:0] free_head
);

  pgwr_state_e state_q;

  logic             awvalid_q;
  logic             wvalid_q;
  logic             bready_q;
  logic [PPA_W-1:0] free_head_q;
  tbl_upd_t         upd_q;  // latched update

  logic upd_fire;
  logic aw_done;
  logic w_done;
  logic b_fire;

  assign upd_ready = (state_q == W_IDLE);
  assign upd_fire  = upd_valid & upd_ready;
  assign aw_done   = !awvalid_q || axi_wr.awready;  // already taken or taken now
  assign w_done    = !wvalid_q || axi_wr.wready;
  assign b_fire    = bready_q & axi_wr.bvalid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= W_IDLE;
      awvalid_q   <= 1'b0;
      wvalid_q    <= 1'b0;
      bready_q    <= 1'b0;
      free_head_q <= PPA_W'(1);  // chain starts at page 1
    end else begin
      case (state_q)
        W_IDLE: begin
          if (upd_fire) begin
            awvalid_q <= 1'b1;  // address and data go out together
            wvalid_q  <= 1'b1;
            state_q   <= W_ADDR;
          end
        end
        W_ADDR: begin
          if (axi_wr.awready) begin
            awvalid_q <= 1'b0;
          end
          if (axi_wr.wready) begin
            wvalid_q <= 1'b0;
          end
          if (aw_done && w_done) begin
            bready_q <= 1'b1;
            state_q  <= W_RESP;
          end
        end
        W_RESP: begin
          if (b_fire) begin
            bready_q <= 1'b0;
            if (axi_wr.bresp == RESP_OKAY) begin
              free_head_q <= upd_q.next_free;  // pop only once the entry is in
            end
            state_q <= W_IDLE;
          end
        end
        default: begin
          state_q <= W_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (upd_fire) begin
      upd_q <= upd;
    end
  end

  assign axi_wr.awaddr  = ATT_BASE + ADDR_W'({upd_q.att_id, 2'b00});
  assign axi_wr.awvalid = awvalid_q;
  assign axi_wr.wdata   = att_word(STS_UNCOMP, upd_q.ppa);  // fresh page, uncompressed
  assign axi_wr.wvalid  = wvalid_q;
  assign axi_wr.bready  = bready_q;
  assign free_head      = free_head_q;

endmodule

/* source/hawk_tbl_mem.sv */
/* hawk table memory
   AXI4-Lite subordinate holding the ATT and TOL regions, loaded at reset */
`timescale 1ns/1ns
module hawk_tbl_mem
  import hawk_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  axil_rd_if.subordinate axi_rd,
  axil_wr_if.subordinate axi_wr
);

  logic [DATA_W-1:0] att_mem [ATT_ENTRIES];
  logic [DATA_W-1:0] tol_mem [TOL_ENTRIES];

  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic [1:0]        rresp_q;
  logic              wr_ack_q;  // awready/wready strobe
  logic              bvalid_q;
  logic [1:0]        bresp_q;

  // region decode, low address bits ignored
  function automatic logic att_sel(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    off = addr - ATT_BASE;
    return off[ADDR_W-1:2] < ATT_ENTRIES;
  endfunction

  function automatic logic tol_sel(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    off = addr - TOL_BASE;
    return off[ADDR_W-1:2] < TOL_ENTRIES;
  endfunction

  function automatic logic [ATT_ID_W-1:0] att_idx(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    off = addr - ATT_BASE;
    return off[ATT_ID_W+1:2];
  endfunction

  function automatic logic [PPA_W-1:0] tol_idx(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    off = addr - TOL_BASE;
    return off[PPA_W+1:2];
  endfunction

  logic ar_fire;
  assign ar_fire = axi_rd.arvalid & axi_rd.arready;

  // table contents, reset loads an empty ATT and the free chain 1 -> 7
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < ATT_ENTRIES; i++) begin
        att_mem[i] <= att_word(STS_DALLOC, NULL_PAGE);
      end
      for (int p = 0; p < TOL_ENTRIES; p++) begin
        tol_mem[p] <= tol_word((p == 0 || p == TOL_ENTRIES - 1) ? NULL_PAGE : PPA_W'(p + 1));
      end
    end else if (wr_ack_q) begin
      if (att_sel(axi_wr.awaddr)) begin
        att_mem[att_idx(axi_wr.awaddr)] <= axi_wr.wdata;
      end else if (tol_sel(axi_wr.awaddr)) begin
        tol_mem[tol_idx(axi_wr.awaddr)] <= axi_wr.wdata;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      wr_ack_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        rvalid_q <= 1'b1;
      end else if (axi_rd.rready) begin
        rvalid_q <= 1'b0;  // held until taken
      end
      // ready one cycle after both valids, response one cycle after that
      wr_ack_q <= axi_wr.awvalid && axi_wr.wvalid && !wr_ack_q && !bvalid_q;
      if (wr_ack_q) begin
        bvalid_q <= 1'b1;
      end else if (axi_wr.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      if (att_sel(axi_rd.araddr)) begin
        rdata_q <= att_mem[att_idx(axi_rd.araddr)];
        rresp_q <= RESP_OKAY;
      end else if (tol_sel(axi_rd.araddr)) begin
        rdata_q <= tol_mem[tol_idx(axi_rd.araddr)];
        rresp_q <= RESP_OKAY;
      end else begin
        rdata_q <= '0;
        rresp_q <= RESP_SLVERR;  // unmapped
      end
    end
    if (wr_ack_q) begin
      bresp_q <= (att_sel(axi_wr.awaddr) || tol_sel(axi_wr.awaddr)) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign axi_rd.arready = !rvalid_q;  // one read in flight
  assign axi_rd.rvalid  = rvalid_q;
  assign axi_rd.rdata   = rdata_q;
  assign axi_rd.rresp   = rresp_q;
  assign axi_wr.awready = wr_ack_q;
  assign axi_wr.wready  = wr_ack_q;
  assign axi_wr.bvalid  = bvalid_q;
  assign axi_wr.bresp   = bresp_q;

endmodule

/* source/hawk_top.sv */
/* hawk page translation engine
   read manager, write manager and table memory behind plain ports */
`timescale 1ns/1ns
module hawk_top
  import hawk_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              lookup_valid,
  input  logic [HPPA_W-1:0] lookup_hppa,
  output logic              lookup_ready,
  output logic              trnsl_valid,
  output logic              trnsl_allow,
  output logic [1:0]        trnsl_sts,
  output logic [PPA_W-1:0]  trnsl_ppa,
  output logic              bus_error
);

  axil_rd_if rd_bus ();  // read manager <-> table memory
  axil_wr_if wr_bus ();  // write manager <-> table memory

  logic             upd_valid;
  logic             upd_ready;
  tbl_upd_t         upd;
  logic [PPA_W-1:0] free_head;
  trnsl_resp_t      trnsl_resp;

  hawk_pgrd_mngr u_pgrd_mngr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lookup_valid (lookup_valid),
    .lookup_hppa  (lookup_hppa),
    .lookup_ready (lookup_ready),
    .axi_rd       (rd_bus.manager),
    .free_head    (free_head),
    .upd_valid    (upd_valid),
    .upd          (upd),
    .upd_ready    (upd_ready),
    .trnsl_valid  (trnsl_valid),
    .trnsl_resp   (trnsl_resp),
    .bus_error    (bus_error)
  );

  hawk_pgwr_mngr u_pgwr_mngr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .upd_valid (upd_valid),
    .upd       (upd),
    .upd_ready (upd_ready),
    .axi_wr    (wr_bus.manager),
    .free_head (free_head)
  );

  hawk_tbl_mem u_tbl_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .axi_rd (rd_bus.subordinate),
    .axi_wr (wr_bus.subordinate)
  );

  // flatten the response
  assign trnsl_allow = trnsl_resp.allow;
  assign trnsl_sts   = trnsl_resp.sts;
  assign trnsl_ppa   = trnsl_resp.ppa;

endmodule

/* sources.f */
common/hawk_pkg.sv
common/axil_rd_if.sv
common/axil_wr_if.sv
pgrd_mngr/hawk_pgrd_mngr.sv
pgwr_mngr/hawk_pgwr_mngr.sv
source/hawk_tbl_mem.sv
source/hawk_top.sv
testbench/tb_hawk.sv

/* testbench/tb_hawk.sv */
/* testbench for the hawk page translation engine
   random and directed lookups checked against a software page table */
`timescale 1ns/1ns
module tb_hawk
  import hawk_pkg::*;
();

  localparam int N_LOOKUPS      = 55;                   // 15 directed + 40 random
  localparam int TIMEOUT_CYCLES = 40 * N_LOOKUPS + 100;

  logic              clk_i;
  logic              rst_ni;
  logic              lookup_valid;
  logic [HPPA_W-1:0] lookup_hppa;
  logic              lookup_ready;
  logic              trnsl_valid;
  logic              trnsl_allow;
  logic [1:0]        trnsl_sts;
  logic [PPA_W-1:0]  trnsl_ppa;
  logic              bus_error;

  // reference page table
  logic             ref_alloc [ATT_ENTRIES];
  logic [PPA_W-1:0] ref_ppa [ATT_ENTRIES];
  int               ref_next;                  // next free page or 8 when the list is empty

  logic [5:0] exp_q [$];   // {allow, sts, ppa} per accepted lookup
  logic       err_pending; // out of range lookup in flight
  int         accept_count;
  int         resp_count;
  int         cycle_count;

  hawk_top dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lookup_valid (lookup_valid),
    .lookup_hppa  (lookup_hppa),
    .lookup_ready (lookup_ready),
    .trnsl_valid  (trnsl_valid),
    .trnsl_allow  (trnsl_allow),
    .trnsl_sts    (trnsl_sts),
    .trnsl_ppa    (trnsl_ppa),
    .bus_error    (bus_error)
  );

  always #5 clk_i = ~clk_i;

  task automatic report_mismatch(input string sig, input logic [7:0] exp_v,
                                 input logic [7:0] act_v);
    $display("Fail at %0t ns: %s expected %0h actual %0h", $time, sig, exp_v, act_v);
    $display("Result: FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_with(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  function automatic logic in_range(input logic [HPPA_W-1:0] hppa);
    return (hppa >= 8'h40) && (hppa <= 8'h4F);
  endfunction

  // hit if mapped or take the next page of the chain or deny
  function automatic logic [5:0] ref_translate(input logic [HPPA_W-1:0] hppa);
    logic [3:0] id;
    id = hppa[3:0];  // hppa is 0x40..0x4f here
    if (ref_alloc[id]) begin
      return {1'b1, 2'b01, ref_ppa[id]};
    end
    if (ref_next > 7) begin
      return {1'b0, 2'b00, 3'd0};
    end
    ref_alloc[id] = 1'b1;
    ref_ppa[id]   = 3'(ref_next);
    ref_next      = ref_next + 1;
    return {1'b1, 2'b01, ref_ppa[id]};
  endfunction

  task automatic clear_model();
    for (int i = 0; i < ATT_ENTRIES; i++) begin
      ref_alloc[i] = 1'b0;
      ref_ppa[i]   = '0;
    end
    ref_next    = 1;  // chain starts at page 1
    err_pending = 1'b0;
    exp_q.delete();
    resp_count  = accept_count;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni       <= 1'b0;
    lookup_valid <= 1'b0;
    clear_model();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // hold valid until the DUT takes it and return on the accepting edge
  task automatic issue_lookup(input logic [HPPA_W-1:0] hppa);
    @(posedge clk_i);
    lookup_valid <= 1'b1;
    lookup_hppa  <= hppa;
    @(negedge clk_i);
    while (!lookup_ready) @(negedge clk_i);
    @(posedge clk_i);
    lookup_valid <= 1'b0;
  endtask

  task automatic lookup_and_wait(input logic [HPPA_W-1:0] hppa);
    issue_lookup(hppa);
    wait (resp_count == accept_count);
  endtask

  // response checker sampled mid cycle
  always @(negedge clk_i) begin : check_resp
    logic [5:0] exp_resp;
    if (rst_ni) begin
      if (trnsl_valid) begin
        assert (exp_q.size() > 0)
          else abort_with("trnsl_valid without an outstanding lookup");
        exp_resp = exp_q.pop_front();
        assert (trnsl_allow == exp_resp[5])
          else report_mismatch("trnsl_allow", exp_resp[5], trnsl_allow);
        assert (trnsl_sts == exp_resp[4:3])
          else report_mismatch("trnsl_sts", exp_resp[4:3], trnsl_sts);
        assert (trnsl_ppa == exp_resp[2:0])
          else report_mismatch("trnsl_ppa", exp_resp[2:0], trnsl_ppa);
        resp_count = resp_count + 1;
      end else if (exp_q.size() > 0 || err_pending) begin
        assert (!lookup_ready)
          else abort_with("lookup_ready high while a lookup is outstanding");
      end
      if (lookup_valid && lookup_ready) begin  // taken on the next rising edge
        if (in_range(lookup_hppa)) begin
          exp_q.push_back(ref_translate(lookup_hppa));
        end else begin
          err_pending = 1'b1;
        end
        accept_count = accept_count + 1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    assert (cycle_count < TIMEOUT_CYCLES)
      else abort_with("timeout, the DUT stopped answering");
  end

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    lookup_valid = 1'b0;
    lookup_hppa  = '0;
    accept_count = 0;
    cycle_count  = 0;
    void'($urandom(10518));
    clear_model();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // fresh pages in chain order and repeats that hit without consuming
    lookup_and_wait(8'h40);
    lookup_and_wait(8'h41);
    lookup_and_wait(8'h42);
    lookup_and_wait(8'h40);
    lookup_and_wait(8'h41);
    for (int h = 8'h43; h <= 8'h46; h++) begin
      lookup_and_wait(8'(h));
    end
    // free list now empty
    lookup_and_wait(8'h47);
    lookup_and_wait(8'h4F);
    lookup_and_wait(8'h40);
    lookup_and_wait(8'h46);

    // unmapped hppa makes bus error stick until reset
    issue_lookup(8'h9C);
    wait (bus_error === 1'b1);
    repeat (20) begin
      @(negedge clk_i);
      assert (bus_error) else abort_with("bus_error dropped before reset");
    end
    apply_reset();
    @(negedge clk_i);
    assert (!bus_error) else report_mismatch("bus_error", 8'd0, bus_error);
    lookup_and_wait(8'h45);  // chain restored, page 1 again

    // random mix with idle gaps and valid held through stalls
    repeat (40) begin
      issue_lookup(HPPA_BASE + 8'($urandom_range(0, 15)));
      repeat ($urandom_range(0, 3)) @(posedge clk_i);
    end
    wait (resp_count == accept_count);
    repeat (5) @(negedge clk_i);

    $display("Result: PASSED");
    $finish;
  end

endmodule
